//--- rtl/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder import main_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic              clear,
    input  logic [ADDR_W:1]   req_addr,
    output bus_region_t       region,
    output logic [ADDR_W:1]   mem_addr,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              oram_cs,
    output logic              snd_cs
);

    bus_region_t       dec_region;
    logic [ADDR_W:1]   dec_addr;

    // first match wins, so only one region can come out
    always_comb begin
        if (req_addr[23:22] == ROM_PFX) begin
            dec_region = ROM;
        end else if (req_addr[23:17] == SND_PFX) begin
            dec_region = SND;
        end else if (req_addr[23:16] == ORAM_PFX) begin
            dec_region = ORAM;
        end else if (req_addr[23:19] == IO_PFX) begin
            dec_region = IO;
        end else if (req_addr[23:16] >= VRAM_FIRST && req_addr[23:16] <= VRAM_LAST) begin
            dec_region = VRAM;
        end else if (req_addr[23:16] == RAM_PFX) begin
            dec_region = RAM;
        end else begin
            dec_region = NONE;
        end
    end

    // RAM is folded down to the bottom of the shared memory, away from VRAM
    always_comb begin
        case (dec_region)
            RAM:     dec_addr = {{(ADDR_W-RAM_AW){1'b0}}, req_addr[RAM_AW:1]};
            default: dec_addr = req_addr;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region  <= NONE;
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            vram_cs <= 1'b0;
            oram_cs <= 1'b0;
            snd_cs  <= 1'b0;
        end else if (load) begin
            region  <= dec_region;
            rom_cs  <= dec_region == ROM;
            ram_cs  <= dec_region == RAM;
            vram_cs <= dec_region == VRAM;
            oram_cs <= dec_region == ORAM;
            snd_cs  <= dec_region == SND;
        end else if (clear) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            vram_cs <= 1'b0;
            oram_cs <= 1'b0;
            snd_cs  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mem_addr <= dec_addr;
        end
    end

endmodule

//--- rtl/bus_cycle_fsm.sv
`timescale 1ns/1ps

module bus_cycle_fsm import main_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_we,
    input  bus_region_t       region,
    input  logic              wait_done,
    input  logic [DATA_W-1:0] rom_data,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [7:0]        snd_data,
    input  logic [DATA_W-1:0] io_rdata,
    output logic              dec_load,
    output logic              dec_clear,
    output logic              timer_start,
    output logic              io_strobe,
    output logic              req_ready,
    output logic [DATA_W-1:0] req_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        MEM_WAIT,
        ACK,
        RELEASE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   no_wait;

    // I/O and unmapped cycles need no memory and skip the timer
    assign no_wait = region == IO || region == NONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt   = state;
        dec_load    = 1'b0;
        dec_clear   = 1'b0;
        timer_start = 1'b0;
        io_strobe   = 1'b0;
        req_ready   = 1'b0;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    dec_load  = 1'b1;
                    state_nxt = DECODE;
                end
            end
            DECODE: begin
                if (no_wait) begin
                    io_strobe = region == IO;
                    state_nxt = ACK;
                end else begin
                    timer_start = 1'b1;
                    state_nxt   = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (wait_done) begin
                    state_nxt = ACK;
                end
            end
            ACK: begin
                req_ready = 1'b1;
                state_nxt = RELEASE;
            end
            RELEASE: begin
                // held request stays here until the master lets go
                dec_clear = 1'b1;
                if (!req_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // read data mux, open bus on writes and outside the acknowledge
    always_comb begin
        req_rdata = OPEN_BUS;
        if (state == ACK && !req_we) begin
            case (region)
                ROM:              req_rdata = rom_data;
                RAM, VRAM, ORAM:  req_rdata = ram_data;
                SND:              req_rdata = {8'hFF, snd_data};
                IO:               req_rdata = io_rdata;
                default:          req_rdata = OPEN_BUS;
            endcase
        end
    end

endmodule

//--- rtl/io_regs.sv
`timescale 1ns/1ps

module io_regs import main_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              strobe,
    input  logic              req_we,
    input  logic [1:0]        req_be,
    input  logic [8:3]        req_addr,
    input  logic [DATA_W-1:0] req_wdata,
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [7:0]        joystick3,
    input  logic [7:0]        joystick4,
    input  logic [3:0]        start_button,
    input  logic [3:0]        coin_input,
    input  logic              dip_test,
    input  logic              eeprom_sdo,
    output logic [DATA_W-1:0] io_rdata,
    output logic              eeprom_sclk,
    output logic              eeprom_sdi,
    output logic              eeprom_scs,
    output logic              snd_rstn,
    output logic              obank
);

    logic [DATA_W-1:0] in0;
    logic [DATA_W-1:0] in1;
    logic [DATA_W-1:0] in2;
    logic              wr;

    // cabinet inputs sampled every cycle
    always_ff @(posedge clk) begin
        in0 <= {joystick2, joystick1};
        in1 <= {joystick4, joystick3};
        in2 <= {coin_input, start_button, 6'h3F, dip_test, eeprom_sdo};
    end

    always_comb begin
        if (req_addr == IO_IN0[8:3]) begin
            io_rdata = in0;
        end else if (req_addr == IO_IN1[8:3]) begin
            io_rdata = in1;
        end else if (req_addr == IO_IN2[8:3]) begin
            io_rdata = in2;
        end else begin
            io_rdata = OPEN_BUS;
        end
    end

    assign wr = strobe && req_we;

    // control latches, each byte lane written on its own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_sdi  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_scs  <= 1'b0;
            snd_rstn    <= 1'b0;
            obank       <= 1'b0;
        end else if (wr) begin
            if (req_addr == IO_OUT[8:3] && req_be[1]) begin
                eeprom_sdi  <= req_wdata[12];
                eeprom_sclk <= req_wdata[13];
                eeprom_scs  <= req_wdata[14];
            end
            if (req_addr == IO_OUT[8:3] && req_be[0]) begin
                snd_rstn <= req_wdata[3];
            end
            if (req_addr == IO_OBANK[8:3] && req_be[0]) begin
                obank <= req_wdata[0];
            end
        end
    end

endmodule

//--- rtl/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic raster,
    input  logic int_ack,
    output logic ipl_vblank_n,
    output logic ipl_raster_n
);

    logic lvbl_last;
    logic raster_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_last    <= 1'b0;
            raster_last  <= 1'b1;
            ipl_vblank_n <= 1'b1;
            ipl_raster_n <= 1'b1;
        end else begin
            lvbl_last   <= lvbl;
            raster_last <= raster;
            // ack wins over an edge in the same cycle
            if (int_ack) begin
                ipl_vblank_n <= 1'b1;
                ipl_raster_n <= 1'b1;
            end else begin
                if (!lvbl && lvbl_last) ipl_vblank_n <= 1'b0;
                if (raster && !raster_last) ipl_raster_n <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/main_bus_pkg.sv
package main_bus_pkg;

    // bus widths
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;
    localparam int ROM_AW = 21;
    localparam int RAM_AW = 15;

    typedef enum logic [2:0] {
        NONE,
        ROM,
        RAM,
        VRAM,
        ORAM,
        SND,
        IO
    } bus_region_t;

    // address map prefixes, each compared against the top bits of the byte address
    localparam logic [1:0] ROM_PFX    = 2'b00;  // bits 23:22
    localparam logic [6:0] SND_PFX    = 7'h30;  // bits 23:17, 60'0000-61'FFFF
    localparam logic [7:0] ORAM_PFX   = 8'h70;  // bits 23:16
    localparam logic [4:0] IO_PFX     = 5'h10;  // bits 23:19, 80'0000-87'FFFF
    localparam logic [7:0] VRAM_FIRST = 8'h90;  // bits 23:16
    localparam logic [7:0] VRAM_LAST  = 8'h92;
    localparam logic [7:0] RAM_PFX    = 8'hFF;  // bits 23:16

    // I/O byte offsets, only bits 8:3 are decoded
    localparam logic [8:0] IO_IN0   = 9'h000;
    localparam logic [8:0] IO_IN1   = 9'h010;
    localparam logic [8:0] IO_IN2   = 9'h020;
    localparam logic [8:0] IO_OUT   = 9'h040;
    localparam logic [8:0] IO_OBANK = 9'h070;

    // bus wait and delay recovery
    localparam int                 WAIT_W   = 4;
    localparam logic [WAIT_W-1:0]  WAIT_MIN = 4'd3;
    localparam int                 DEBT_W   = 4;
    localparam logic [DEBT_W-1:0]  DEBT_MAX = 4'd15;

    localparam logic [DATA_W-1:0]  OPEN_BUS = 16'hFFFF;

endpackage

//--- rtl/main_bus_top.sv
`timescale 1ns/1ps

module main_bus_top import main_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // bus master
    input  logic              req_valid,
    input  logic [ADDR_W:1]   req_addr,
    input  logic              req_we,
    input  logic [1:0]        req_be,
    input  logic [DATA_W-1:0] req_wdata,
    output logic              req_ready,
    output logic [DATA_W-1:0] req_rdata,
    // memories
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              oram_cs,
    output logic              snd_cs,
    output logic [ADDR_W:1]   mem_addr,
    input  logic [DATA_W-1:0] rom_data,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [7:0]        snd_data,
    input  logic              rom_ok,
    input  logic              ram_ok,
    input  logic              snd_ok,
    // video
    input  logic              lvbl,
    input  logic              raster,
    input  logic              int_ack,
    output logic              ipl_vblank_n,
    output logic              ipl_raster_n,
    // cabinet
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [7:0]        joystick3,
    input  logic [7:0]        joystick4,
    input  logic [3:0]        start_button,
    input  logic [3:0]        coin_input,
    input  logic              dip_test,
    input  logic              eeprom_sdo,
    output logic              eeprom_sclk,
    output logic              eeprom_sdi,
    output logic              eeprom_scs,
    output logic              snd_rstn,
    output logic              obank
);

    bus_region_t       region;
    logic              dec_load;
    logic              dec_clear;
    logic              timer_start;
    logic              wait_done;
    logic              io_strobe;
    logic              mem_ok;
    logic [DATA_W-1:0] io_rdata;

    // ok of whichever memory is selected
    assign mem_ok = (rom_cs && rom_ok) || ((ram_cs || vram_cs || oram_cs) && ram_ok)
                  || (snd_cs && snd_ok);

    addr_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .load       (dec_load),
        .clear      (dec_clear),
        .req_addr   (req_addr),
        .region     (region),
        .mem_addr   (mem_addr),
        .rom_cs     (rom_cs),
        .ram_cs     (ram_cs),
        .vram_cs    (vram_cs),
        .oram_cs    (oram_cs),
        .snd_cs     (snd_cs)
    );

    bus_cycle_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_we      (req_we),
        .region      (region),
        .wait_done   (wait_done),
        .rom_data    (rom_data),
        .ram_data    (ram_data),
        .snd_data    (snd_data),
        .io_rdata    (io_rdata),
        .dec_load    (dec_load),
        .dec_clear   (dec_clear),
        .timer_start (timer_start),
        .io_strobe   (io_strobe),
        .req_ready   (req_ready),
        .req_rdata   (req_rdata)
    );

    wait_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .start  (timer_start),
        .mem_ok (mem_ok),
        .lvbl   (lvbl),
        .done   (wait_done)
    );

    io_regs u_io (
        .clk          (clk),
        .rst          (rst),
        .strobe       (io_strobe),
        .req_we       (req_we),
        .req_be       (req_be),
        .req_addr     (req_addr[8:3]),
        .req_wdata    (req_wdata),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .joystick3    (joystick3),
        .joystick4    (joystick4),
        .start_button (start_button),
        .coin_input   (coin_input),
        .dip_test     (dip_test),
        .eeprom_sdo   (eeprom_sdo),
        .io_rdata     (io_rdata),
        .eeprom_sclk  (eeprom_sclk),
        .eeprom_sdi   (eeprom_sdi),
        .eeprom_scs   (eeprom_scs),
        .snd_rstn     (snd_rstn),
        .obank        (obank)
    );

    irq_ctrl u_irq (
        .clk          (clk),
        .rst          (rst),
        .lvbl         (lvbl),
        .raster       (raster),
        .int_ack      (int_ack),
        .ipl_vblank_n (ipl_vblank_n),
        .ipl_raster_n (ipl_raster_n)
    );

endmodule

//--- rtl/wait_timer.sv
`timescale 1ns/1ps

module wait_timer import main_bus_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic mem_ok,
    input  logic lvbl,
    output logic done
);

    logic              active;
    logic [WAIT_W-1:0] cnt;
    logic [DEBT_W-1:0] debt;
    logic              lvbl_last;
    logic              normal_done;
    logic              early_done;
    logic              late;

    // cnt holds the cycles since the select rose, ack comes one cycle after done
    assign normal_done = cnt >= WAIT_MIN - 4'd1;
    assign early_done  = cnt == WAIT_MIN - 4'd2 && debt != '0;
    assign done        = active && mem_ok && (normal_done || early_done);

    // ok stays up once raised, so finishing past the normal point means it came late
    assign late = cnt > WAIT_MIN - 4'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= 4'd1;
        end else if (done) begin
            active <= 1'b0;
        end else if (active && cnt != '1) begin
            cnt <= cnt + 4'd1;
        end
    end

    // recovery debt, wiped once per frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            debt      <= '0;
            lvbl_last <= 1'b0;
        end else begin
            lvbl_last <= lvbl;
            if (!lvbl && lvbl_last) begin
                debt <= '0;
            end else if (done && early_done) begin
                debt <= debt - 4'd1;
            end else if (done && late && debt != DEBT_MAX) begin
                debt <= debt + 4'd1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the main bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_main_bus \
        -f sources.f --Mdir obj_dir -o sim_main_bus > build.log 2>&1; then
    echo "build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/sim_main_bus > sim.log 2>&1; then
    echo "simulation ended with an error, see sim.log"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sources.f
rtl/main_bus_pkg.sv
rtl/addr_decoder.sv
rtl/bus_cycle_fsm.sv
rtl/wait_timer.sv
rtl/io_regs.sv
rtl/irq_ctrl.sv
rtl/main_bus_top.sv
tests/main_bus_properties.sv
tests/tb_main_bus.sv

//--- tests/main_bus_properties.sv
`timescale 1ns/1ps

module main_bus_properties import main_bus_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic [23:1] req_addr,
    input logic        req_we,
    input logic [1:0]  req_be,
    input logic [15:0] req_wdata,
    input logic        req_ready,
    input logic [15:0] req_rdata,
    input logic        rom_cs,
    input logic        ram_cs,
    input logic        vram_cs,
    input logic        oram_cs,
    input logic        snd_cs,
    input logic        rom_ok,
    input logic        ram_ok,
    input logic        snd_ok,
    input logic        lvbl,
    input logic        raster,
    input logic        int_ack,
    input logic        ipl_vblank_n,
    input logic        ipl_raster_n,
    input logic        eeprom_sclk,
    input logic        eeprom_sdi,
    input logic        eeprom_scs,
    input logic        snd_rstn,
    input logic        obank
);

    logic        any_cs;
    logic        act_ok;
    logic        cs_match;
    logic        no_mem;
    logic        io_out;
    logic        io_obank;
    logic        acked;
    logic [23:0] b;

    assign b        = {req_addr, 1'b0};
    assign any_cs   = rom_cs || ram_cs || vram_cs || oram_cs || snd_cs;
    assign act_ok   = (rom_cs && rom_ok) || ((ram_cs || vram_cs || oram_cs) && ram_ok)
                    || (snd_cs && snd_ok);
    // each select against the byte address map
    assign cs_match = rom_cs == (b <= 24'h3FFFFF)
                   && snd_cs == (b >= 24'h600000 && b <= 24'h61FFFF)
                   && oram_cs == (b >= 24'h700000 && b <= 24'h70FFFF)
                   && vram_cs == (b >= 24'h900000 && b <= 24'h92FFFF)
                   && ram_cs == (b >= 24'hFF0000);
    assign no_mem   = !(b <= 24'h3FFFFF || (b >= 24'h600000 && b <= 24'h61FFFF)
                   || (b >= 24'h700000 && b <= 24'h70FFFF)
                   || (b >= 24'h900000 && b <= 24'h92FFFF) || b >= 24'hFF0000);
    assign io_out   = b >= 24'h800000 && b <= 24'h87FFFF && req_addr[8:3] == 6'h08;
    assign io_obank = b >= 24'h800000 && b <= 24'h87FFFF && req_addr[8:3] == 6'h0E;

    // set by an acknowledge, held until the master lets go
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acked <= 1'b0;
        end else if (req_ready) begin
            acked <= 1'b1;
        end else if (!req_valid) begin
            acked <= 1'b0;
        end
    end

    a_onehot: assert property (@(posedge clk) disable iff (rst)
        req_ready |-> $onehot0({rom_cs, ram_cs, vram_cs, oram_cs, snd_cs})) else $error;
    a_map_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(any_cs) |-> cs_match) else $error;
    a_map_ack: assert property (@(posedge clk) disable iff (rst)
        req_ready |-> cs_match) else $error;
    a_snd_upper: assert property (@(posedge clk) disable iff (rst)
        req_ready && !req_we && snd_cs |-> req_rdata[15:8] == 8'hFF) else $error;
    a_open_bus: assert property (@(posedge clk) disable iff (rst)
        req_ready && !req_we && no_mem && !(b >= 24'h800000 && b <= 24'h87FFFF)
        |-> req_rdata == 16'hFFFF) else $error;
    a_eeprom: assert property (@(posedge clk) disable iff (rst)
        !$stable({eeprom_scs, eeprom_sclk, eeprom_sdi})
        |-> req_ready && req_we && io_out && req_be[1]
            && {eeprom_scs, eeprom_sclk, eeprom_sdi} == req_wdata[14:12]) else $error;
    a_snd_rstn: assert property (@(posedge clk) disable iff (rst)
        !$stable(snd_rstn) |-> req_ready && req_we && io_out && req_be[0]
            && snd_rstn == req_wdata[3]) else $error;
    a_obank: assert property (@(posedge clk) disable iff (rst)
        !$stable(obank) |-> req_ready && req_we && io_obank && req_be[0]
            && obank == req_wdata[0]) else $error;
    a_mem_ok: assert property (@(posedge clk) disable iff (rst)
        req_ready && any_cs |-> act_ok) else $error;
    a_min_wait: assert property (@(posedge clk) disable iff (rst)
        $rose(any_cs) |-> !req_ready ##1 !req_ready) else $error;
    a_io_time: assert property (@(posedge clk) disable iff (rst)
        $rose(req_valid) && no_mem |-> !req_ready ##1 !req_ready ##1 req_ready) else $error;
    a_vbl_irq: assert property (@(posedge clk) disable iff (rst)
        $fell(lvbl) && !int_ack |=> !ipl_vblank_n) else $error;
    a_raster_irq: assert property (@(posedge clk) disable iff (rst)
        $rose(raster) && !int_ack |=> !ipl_raster_n) else $error;
    a_irq_ack: assert property (@(posedge clk) disable iff (rst)
        int_ack |=> ipl_vblank_n && ipl_raster_n) else $error;
    a_pulse: assert property (@(posedge clk) disable iff (rst)
        req_ready |=> !req_ready) else $error;
    a_with_valid: assert property (@(posedge clk) disable iff (rst)
        req_ready |-> req_valid) else $error;
    a_no_second: assert property (@(posedge clk) disable iff (rst)
        acked |-> !req_ready) else $error;

endmodule

bind main_bus_top main_bus_properties props_i (.*);

//--- tests/tb_main_bus.sv
`timescale 1ns/1ps

module tb_main_bus import main_bus_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic [23:1]       req_addr;
    logic              req_we;
    logic [1:0]        req_be;
    logic [15:0]       req_wdata;
    logic              req_ready;
    logic [15:0]       req_rdata;
    logic              rom_cs;
    logic              ram_cs;
    logic              vram_cs;
    logic              oram_cs;
    logic              snd_cs;
    logic [23:1]       mem_addr;
    logic [15:0]       rom_data;
    logic [15:0]       ram_data;
    logic [7:0]        snd_data;
    logic              rom_ok;
    logic              ram_ok;
    logic              snd_ok;
    logic              lvbl;
    logic              raster;
    logic              int_ack;
    logic              ipl_vblank_n;
    logic              ipl_raster_n;
    logic [7:0]        joystick1;
    logic [7:0]        joystick2;
    logic [7:0]        joystick3;
    logic [7:0]        joystick4;
    logic [3:0]        start_button;
    logic [3:0]        coin_input;
    logic              dip_test;
    logic              eeprom_sdo;
    logic              eeprom_sclk;
    logic              eeprom_sdi;
    logic              eeprom_scs;
    logic              snd_rstn;
    logic              obank;
    logic [15:0]       lfsr;
    logic [3:0]        mem_lat;
    logic [3:0]        mcnt;
    logic              any_cs;
    int                ack_cycles;

    main_bus_top main_bus_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign any_cs = rom_cs || ram_cs || vram_cs || oram_cs || snd_cs;

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // memory contents, every address bit takes part
    function automatic logic [15:0] rom_word(input logic [23:1] a);
        return a[16:1] ^ {2'b00, a[23:17], 7'h35};
    endfunction

    function automatic logic [15:0] ram_word(input logic [23:1] a);
        return ~a[16:1] ^ {a[23:17], 9'h0C3};
    endfunction

    function automatic logic [7:0] snd_byte(input logic [23:1] a);
        return a[8:1] ^ a[16:9] ^ {1'b0, a[23:17]};
    endfunction

    function automatic bus_region_t region_of(input logic [23:1] a);
        logic [23:0] b;
        b = {a, 1'b0};
        if (b <= 24'h3FFFFF) return ROM;
        if (b >= 24'h600000 && b <= 24'h61FFFF) return SND;
        if (b >= 24'h700000 && b <= 24'h70FFFF) return ORAM;
        if (b >= 24'h800000 && b <= 24'h87FFFF) return IO;
        if (b >= 24'h900000 && b <= 24'h92FFFF) return VRAM;
        if (b >= 24'hFF0000) return RAM;
        return NONE;
    endfunction

    function automatic logic [15:0] expected_read(input logic [23:1] a);
        case (region_of(a))
            ROM:       return rom_word(a);
            RAM:       return ram_word({8'h00, a[15:1]});
            VRAM, ORAM: return ram_word(a);
            SND:       return {8'hFF, snd_byte(a)};
            IO: begin
                case (a[8:3])
                    6'd0:    return {joystick2, joystick1};
                    6'd2:    return {joystick4, joystick3};
                    6'd4:    return {coin_input, start_button, 6'h3F, dip_test, eeprom_sdo};
                    default: return 16'hFFFF;
                endcase
            end
            default:   return 16'hFFFF;
        endcase
    endfunction

    function automatic logic [23:1] random_addr();
        logic [2:0]  sel;
        logic [23:0] b;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0: b = {2'b00, 22'(rand_bits(22))};
            3'd1: b = 24'h600000 | 24'(rand_bits(17));
            3'd2: b = {8'h70, 16'(rand_bits(16))};
            3'd3: b = {8'h90 + 8'(rand_bits(1)) + 8'(rand_bits(1)), 16'(rand_bits(16))};
            3'd4: b = {8'hFF, 16'(rand_bits(16))};
            3'd5: b = 24'h800000 | {15'h0, 3'(rand_bits(3)), 6'h00} | 24'(rand_bits(1));
            3'd6: b = 24'hA00000 | 24'(rand_bits(20));
            default: b = 24'h400000 | 24'(rand_bits(21));
        endcase
        return b[23:1];
    endfunction

    // memory latency model, ok stays up until the select drops
    always @(posedge clk) begin
        rom_data <= rom_word(mem_addr);
        ram_data <= ram_word(mem_addr);
        snd_data <= snd_byte(mem_addr);
        if (!any_cs) begin
            mcnt   <= 4'd0;
            rom_ok <= 1'b0;
            ram_ok <= 1'b0;
            snd_ok <= 1'b0;
        end else begin
            if (mcnt != 4'hF) mcnt <= mcnt + 4'd1;
            rom_ok <= rom_cs && mcnt >= mem_lat;
            ram_ok <= (ram_cs || vram_cs || oram_cs) && mcnt >= mem_lat;
            snd_ok <= snd_cs && mcnt >= mem_lat;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check16(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("a DUT output differs from the expected value");
        end
    endtask

    task automatic randomize_cabinet();
        @(posedge clk);
        joystick1    <= 8'(rand_bits(8));
        joystick2    <= 8'(rand_bits(8));
        joystick3    <= 8'(rand_bits(8));
        joystick4    <= 8'(rand_bits(8));
        start_button <= 4'(rand_bits(4));
        coin_input   <= 4'(rand_bits(4));
        dip_test     <= 1'(rand_bits(1));
        eeprom_sdo   <= 1'(rand_bits(1));
    endtask

    // one master transfer, hold keeps valid up after the acknowledge
    task automatic bus_access(input logic [23:1] addr, input logic we, input logic [1:0] be,
                              input logic [15:0] wdata, input logic [3:0] lat, input int hold);
        logic [15:0] exp;
        int          waited;
        int          cs_cyc;
        @(posedge clk);
        req_valid <= 1'b1;
        req_addr  <= addr;
        req_we    <= we;
        req_be    <= be;
        req_wdata <= wdata;
        mem_lat   <= lat;
        waited = 0;
        cs_cyc = 0;
        do begin
            @(negedge clk);
            waited++;
            if (any_cs) cs_cyc++;
        end while (!req_ready && waited < 40);
        if (!req_ready) begin
            abort_run("the DUT gave no acknowledge within 40 cycles");
        end else begin
            ack_cycles = cs_cyc;
            // cabinet inputs have been steady for the whole transfer
            exp = expected_read(addr);
            if (!we) check16("req_rdata", req_rdata, exp);
            @(posedge clk);
            repeat (hold) @(posedge clk);
            req_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    initial begin
        logic [15:0] d;
        logic [23:1] a;
        logic [1:0]  be;
        lfsr = 16'd71;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_we = 1'b0;
        req_be = 2'b00;
        req_wdata = '0;
        lvbl = 1'b1;
        raster = 1'b0;
        int_ack = 1'b0;
        {joystick1, joystick2, joystick3, joystick4} = '0;
        {start_button, coin_input, dip_test, eeprom_sdo} = '0;
        {rom_data, ram_data, snd_data} = '0;
        {rom_ok, ram_ok, snd_ok} = '0;
        mem_lat = 4'd0;
        mcnt = 4'd0;
        ack_cycles = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check16("eeprom_sdi,sclk,scs,snd_rstn,obank",
                {11'h0, eeprom_sdi, eeprom_sclk, eeprom_scs, snd_rstn, obank}, 16'h0);
        check16("ipl_vblank_n,ipl_raster_n", {14'h0, ipl_vblank_n, ipl_raster_n}, 16'h3);
        check16("req_ready", {15'h0, req_ready}, 16'h0);
        randomize_cabinet();

        // input ports, an unused offset and an unmapped address
        bus_access(23'h400000, 1'b0, 2'b11, 16'h0, 4'd0, 0);
        bus_access(23'h400008, 1'b0, 2'b11, 16'h0, 4'd0, 0);
        bus_access(23'h400010, 1'b0, 2'b11, 16'h0, 4'd0, 1);
        bus_access(23'h400018, 1'b0, 2'b11, 16'h0, 4'd0, 0);
        bus_access(23'h500000, 1'b0, 2'b11, 16'h0, 4'd0, 0);

        // control latches, one byte lane at a time
        d = 16'(rand_bits(16));
        bus_access(23'h400020, 1'b1, 2'b10, d, 4'd0, 0);
        check16("eeprom_scs,sclk,sdi", {13'h0, eeprom_scs, eeprom_sclk, eeprom_sdi},
                {13'h0, d[14:12]});
        check16("snd_rstn", {15'h0, snd_rstn}, 16'h0);
        bus_access(23'h400020, 1'b1, 2'b01, ~d | 16'h0008, 4'd0, 0);
        check16("snd_rstn", {15'h0, snd_rstn}, 16'h1);
        check16("eeprom_scs,sclk,sdi", {13'h0, eeprom_scs, eeprom_sclk, eeprom_sdi},
                {13'h0, d[14:12]});
        bus_access(23'h400038, 1'b1, 2'b01, 16'h0001, 4'd0, 0);
        check16("obank", {15'h0, obank}, 16'h1);
        bus_access(23'h400038, 1'b1, 2'b10, 16'h0000, 4'd0, 0);
        check16("obank", {15'h0, obank}, 16'h1);

        // build up debt with slow reads, then a fast one finishes early
        bus_access(23'h001234, 1'b0, 2'b11, 16'h0, 4'd0, 0);
        check16("ack_cycles", 16'(ack_cycles), 16'd4);
        repeat (4) bus_access({2'b00, 21'(rand_bits(21))}, 1'b0, 2'b11, 16'h0, 4'd7, 0);
        bus_access(23'h7F8002, 1'b0, 2'b11, 16'h0, 4'd0, 0);
        check16("ack_cycles", 16'(ack_cycles), 16'd3);

        // interrupts
        @(posedge clk);
        lvbl <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check16("ipl_vblank_n", {15'h0, ipl_vblank_n}, 16'h0);
        @(posedge clk);
        raster <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check16("ipl_raster_n", {15'h0, ipl_raster_n}, 16'h0);
        @(posedge clk);
        int_ack <= 1'b1;
        @(posedge clk);
        int_ack <= 1'b0;
        @(negedge clk);
        check16("ipl_vblank_n,ipl_raster_n", {14'h0, ipl_vblank_n, ipl_raster_n}, 16'h3);
        @(posedge clk);
        lvbl   <= 1'b1;
        raster <= 1'b0;

        for (int i = 0; i < 80; i++) begin
            if (i % 8 == 0) randomize_cabinet();
            a  = random_addr();
            be = 2'(rand_bits(2));
            if (be == 2'b00) be = 2'b11;
            bus_access(a, 1'(rand_bits(1)), be, 16'(rand_bits(16)), 4'(rand_bits(3)),
                       int'(rand_bits(2)) % 3);
        end
        $display("** PASS **");
        $finish;
    end

endmodule
